// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_pitaya_core
FILELIST  := build.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+dv
rtl/pitaya_pkg.sv
rtl/sys_regs.sv
rtl/lin_calib.sv
rtl/wave_gen.sv
rtl/dac_router.sv
rtl/pitaya_core_top.sv
dv/tb_pitaya_core.sv

// ==== dv/tb_model.svh ====
/*
 * Reference model of the core datapath.
 * Saturation, gain and offset correction and generator shapes,
 * computed on plain integers.
 */

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Clip to the signed 14-bit range
function automatic int sat14(int v);
  if (v > 8191) begin
    return 8191;
  end
  if (v < -8192) begin
    return -8192;
  end
  return v;
endfunction

// 14-bit word as a signed integer
function automatic int sext14(logic [13:0] v);
  return $signed(v);
endfunction

// Low 14 bits, as seen on the DAC bus
function automatic logic [31:0] word14(int v);
  return {18'b0, v[13:0]};
endfunction

// Gain in units of 1/8192, then offset, then clip
function automatic int calib(int x, int mul, int sum);
  int prod;
  prod = x * mul;                    // At most 2^28 in magnitude
  return sat14((prod >>> 13) + sum);
endfunction

// Generator output for a given phase
function automatic int gen_out(wave_e wave, logic [15:0] phase, logic [15:0] step);
  case (wave)
    WAVE_SAW:    return sext14(phase[15:2]);
    WAVE_SQUARE: return phase[15] ? -8192 : 8191;
    WAVE_DC:     return sext14(step[13:0]);   // Step doubles as level
    default:     return 0;
  endcase
endfunction

`endif

// ==== dv/tb_pitaya_core.sv ====
/*
 * Testbench of the acquisition and generation core.
 * Drives the register bus and random ADC samples from an LCG,
 * and checks capture, loopback, generators and routing.
 */

module tb_pitaya_core import pitaya_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  `include "tb_model.svh"

  localparam logic [31:0] TB_ID  = 32'h7e57_0046;  // Core ID seen by the DUT
  localparam int          RD_TMO = 20;             // Cycles to wait for read data

  logic             adc_clk;
  logic             top_rst;
  sample_t    [1:0] adc_dat_i;
  bus_req_t         bus_i;
  logic      [31:0] bus_rdata_o;
  logic             bus_rvalid_o;
  logic      [13:0] dac_dat_o;
  logic             dac_sel_o;
  logic             dac_wrt_o;

  int unsigned lcg_state = 46;
  int          cyc;             // Rising edges seen so far
  int          hist [2][16];    // ADC inputs by cycle and channel
  int          adc_mul [2];
  int          adc_sum [2];
  int          dac_mul [2];
  int          dac_sum [2];

  pitaya_core_top #(.ID_VALUE (TB_ID)) i_dut (
    .adc_clk      (adc_clk     ),
    .top_rst      (top_rst     ),
    .adc_dat_i    (adc_dat_i   ),
    .bus_i        (bus_i       ),
    .bus_rdata_o  (bus_rdata_o ),
    .bus_rvalid_o (bus_rvalid_o),
    .dac_dat_o    (dac_dat_o   ),
    .dac_sel_o    (dac_sel_o   ),
    .dac_wrt_o    (dac_wrt_o   )
  );

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;  // 100 ns period
  end

  //////////////////////////////
  // Random numbers
  //////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_sample();
    logic [31:0] r;
    r = lcg_next();
    return sext14(r[31:18]);  // Upper bits spread better
  endfunction

  function automatic int rand_mul();
    logic [31:0] r;
    r = lcg_next();
    return $signed(r[31:16]);
  endfunction

  // Gain between 0.5 and 1.5
  function automatic int rand_gain();
    logic [31:0] r;
    r = lcg_next();
    return 4096 + int'(r[31:19]);
  endfunction

  //////////////////////////////
  // Cycle, check and bus tasks
  //////////////////////////////

  // Log current inputs, then move to the next drive point
  task automatic tick();
    hist[0][cyc % 16] = sext14(adc_dat_i[0]);
    hist[1][cyc % 16] = sext14(adc_dat_i[1]);
    @(posedge adc_clk);
    #5;
    cyc++;
  endtask

  task automatic check_eq(string what, logic [31:0] got, logic [31:0] want);
    if (got !== want) begin
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, want);
      $display("TB FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic drive_random_adc();
    adc_dat_i[0] = 14'(rand_sample());
    adc_dat_i[1] = 14'(rand_sample());
  endtask

  task automatic bus_write(reg_addr_e addr, logic [31:0] data);
    bus_i.wr    = 1'b1;
    bus_i.addr  = addr;
    bus_i.wdata = data;
    tick();
    bus_i.wr    = 1'b0;
  endtask

  task automatic bus_read(reg_addr_e addr, output logic [31:0] data);
    int n;
    bus_i.rd   = 1'b1;
    bus_i.addr = addr;
    tick();
    bus_i.rd   = 1'b0;
    n = 0;
    while (!bus_rvalid_o) begin
      if (n == RD_TMO) begin
        $display("TB FAILED");
        $fatal(1, "Read data valid never came back from the register bank");
      end
      tick();
      n++;
    end
    data = bus_rdata_o;
    tick();
    check_eq("read valid pulse length", bus_rvalid_o, 0);  // Single cycle
  endtask

  task automatic set_cal(reg_addr_e addr, int mul, int sum);
    bus_write(addr, {mul[15:0], 2'b00, sum[13:0]});
  endtask

  function automatic logic [31:0] gen_word(logic en, wave_e wave, logic [15:0] step);
    return {en, 5'b0, wave, 8'b0, step};
  endfunction

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] mux_word;
    logic [31:0] wr_word;
    logic        prev_sel;
    int          ch;
    int          n;
    int          s0;
    int          s1;
    int          want;
    int          step [2];
    int          prev [2];

    adc_dat_i = '0;
    bus_i     = '0;
    top_rst   = 1'b1;
    cyc       = 0;

    // Reset state
    for (int i = 0; i < 10; i++) begin
      tick();
      check_eq("dac_wrt_o in reset", dac_wrt_o, 0);
      check_eq("dac_dat_o in reset", dac_dat_o, 0);
    end
    top_rst = 1'b0;
    check_eq("dac_wrt_o after reset", dac_wrt_o, 0);
    n = 0;
    while (!dac_wrt_o) begin
      if (n == 10) begin
        $display("TB FAILED");
        $fatal(1, "DAC write strobe never went high after reset");
      end
      tick();
      n++;
    end
    for (int i = 0; i < 8; i++) begin
      check_eq("silent DAC after reset", dac_dat_o, 0);
      tick();
    end
    bus_read(REG_ID, rd);
    check_eq("REG_ID", rd, TB_ID);
    bus_read(REG_ADC_CAL0, rd);
    check_eq("REG_ADC_CAL0 reset value", rd, 32'h2000_0000);  // Unity gain and zero offset

    // ADC calibration and capture with saturation in the first round
    for (int r = 0; r < 8; r++) begin
      for (int c = 0; c < 2; c++) begin
        adc_mul[c] = (r == 0) ? 32767 : rand_mul();
        adc_sum[c] = (r == 0) ? ((c == 0) ? 8000 : -8000) : rand_sample();
      end
      set_cal(REG_ADC_CAL0, adc_mul[0], adc_sum[0]);
      set_cal(REG_ADC_CAL1, adc_mul[1], adc_sum[1]);
      for (int i = 0; i < 4; i++) begin
        drive_random_adc();
        tick();
      end
      s0 = (r == 0) ? 8191 : rand_sample();
      s1 = (r == 0) ? -8192 : rand_sample();
      adc_dat_i[0] = 14'(s0);
      adc_dat_i[1] = 14'(s1);
      for (int i = 0; i < 5; i++) begin
        tick();                          // Let the pipeline settle
      end
      bus_read(REG_CAPTURE, rd);
      want = calib(s0, adc_mul[0], adc_sum[0]);
      check_eq("capture ch0", rd[15:0], want[15:0]);
      want = calib(s1, adc_mul[1], adc_sum[1]);
      check_eq("capture ch1", rd[31:16], want[15:0]);
    end

    // Loopback through both calibrators
    for (int c = 0; c < 2; c++) begin
      adc_mul[c] = rand_gain();
      adc_sum[c] = rand_sample() / 8;
      dac_mul[c] = rand_gain();
      dac_sum[c] = rand_sample() / 8;
    end
    set_cal(REG_ADC_CAL0, adc_mul[0], adc_sum[0]);
    set_cal(REG_ADC_CAL1, adc_mul[1], adc_sum[1]);
    set_cal(REG_DAC_CAL0, dac_mul[0], dac_sum[0]);
    set_cal(REG_DAC_CAL1, dac_mul[1], dac_sum[1]);
    bus_write(REG_MUX, {28'b0, SRC_LOOP, SRC_LOOP});
    prev_sel = dac_sel_o;
    for (int i = 0; i < 64; i++) begin
      ch = dac_sel_o;
      if (i >= 8) begin
        want = calib(hist[ch][(cyc - 6) % 16], adc_mul[ch], adc_sum[ch]);
        want = calib(want, dac_mul[ch], dac_sum[ch]);
        check_eq("loopback sample", dac_dat_o, word14(want));
        check_eq("dac_wrt_o in loopback", dac_wrt_o, 1);
      end
      if (i > 0) begin
        check_eq("dac_sel_o alternation", dac_sel_o, !prev_sel);
      end
      prev_sel = dac_sel_o;
      drive_random_adc();
      tick();
    end

    // Sawtooth through a unity DAC path
    set_cal(REG_DAC_CAL0, 8192, 0);
    set_cal(REG_DAC_CAL1, 8192, 0);
    for (int c = 0; c < 2; c++) begin
      step[c] = int'(lcg_next() >> 16) & 32'hfffc;  // Multiple of 4
      prev[c] = 0;
    end
    bus_write(REG_GEN0, gen_word(1'b1, WAVE_SAW, step[0][15:0]));
    bus_write(REG_GEN1, gen_word(1'b1, WAVE_SAW, step[1][15:0]));
    bus_write(REG_MUX, {28'b0, SRC_GEN, SRC_GEN});
    for (int i = 0; i < 48; i++) begin
      ch = dac_sel_o;
      if (i >= 12) begin
        check_eq("sawtooth advance", (dac_dat_o - prev[ch]) & 32'h3fff,
                 (step[ch] / 2) & 32'h3fff);
      end
      prev[ch] = dac_dat_o;
      tick();
    end

    // Square on ch0 and DC on ch1 with random DAC calibration
    dac_mul[1] = rand_gain();
    dac_sum[1] = rand_sample() / 4;
    step[0]    = int'(lcg_next() >> 20) | 32'h800;  // Toggles within the run
    step[1]    = int'(lcg_next() >> 16);
    set_cal(REG_DAC_CAL1, dac_mul[1], dac_sum[1]);
    bus_write(REG_GEN0, gen_word(1'b1, WAVE_SQUARE, step[0][15:0]));
    bus_write(REG_GEN1, gen_word(1'b1, WAVE_DC, step[1][15:0]));
    for (int i = 0; i < 48; i++) begin
      if (i >= 8) begin
        if (dac_sel_o == 1'b0) begin
          want = gen_out(WAVE_SQUARE, 16'h0000, step[0][15:0]);
          if (dac_dat_o != want[13:0]) begin
            want = gen_out(WAVE_SQUARE, 16'h8000, step[0][15:0]);
          end
          check_eq("square level", dac_dat_o, word14(want));
        end else begin
          want = calib(gen_out(WAVE_DC, 16'h0000, step[1][15:0]), dac_mul[1], dac_sum[1]);
          check_eq("DC level", dac_dat_o, word14(want));
        end
      end
      tick();
    end

    // SRC_OFF leaves only the DAC offset
    for (int c = 0; c < 2; c++) begin
      dac_mul[c] = rand_mul();
      dac_sum[c] = rand_sample();
    end
    set_cal(REG_DAC_CAL0, dac_mul[0], dac_sum[0]);
    set_cal(REG_DAC_CAL1, dac_mul[1], dac_sum[1]);
    bus_write(REG_MUX, {28'b0, SRC_OFF, SRC_OFF});
    for (int i = 0; i < 24; i++) begin
      ch = dac_sel_o;
      if (i >= 8) begin
        want = calib(0, dac_mul[ch], dac_sum[ch]);
        check_eq("silent channel", dac_dat_o, word14(want));
      end
      tick();
    end

    // Register readback of the mapped fields
    mux_word = {28'b0, src_e'(lcg_next() % 3), src_e'(lcg_next() % 3)};
    bus_write(REG_MUX, mux_word);
    bus_read(REG_MUX, rd);
    check_eq("REG_MUX readback", rd, mux_word & 32'h0000_000f);
    for (int a = REG_ADC_CAL0; a <= REG_DAC_CAL1; a++) begin
      wr_word = lcg_next();
      bus_write(reg_addr_e'(a), wr_word);
      bus_read(reg_addr_e'(a), rd);
      check_eq("calibration readback", rd, wr_word & 32'hffff_3fff);
    end
    for (int a = REG_GEN0; a <= REG_GEN1; a++) begin
      wr_word = gen_word(lcg_next() >> 31, wave_e'(lcg_next() % 3), lcg_next() >> 16);
      bus_write(reg_addr_e'(a), wr_word | 32'h7cff_0000);  // Junk in unused bits
      bus_read(reg_addr_e'(a), rd);
      check_eq("generator readback", rd, wr_word);
    end

    // Unknown addresses read zero and drop writes
    bus_write(reg_addr_e'(4'd12), 32'hffff_ffff);
    bus_read(REG_MUX, rd);
    check_eq("REG_MUX after unmapped write", rd, mux_word);
    for (int a = 9; a < 16; a++) begin
      bus_read(reg_addr_e'(a), rd);
      check_eq("unmapped read", rd, 0);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule : tb_pitaya_core

// ==== rtl/dac_router.sv ====
/*
 * DAC source selection and channel interleaver.
 * Picks silence, generator or ADC loopback per channel, then
 * alternates the corrected channels onto the combined DAC bus.
 */

module dac_router import pitaya_pkg::*; (
  input  logic              adc_clk,
  input  logic              top_rst,
  input  mux_cfg_t          mux_cfg_i,
  input  sample_t     [1:0] adc_dat_i,      // Corrected ADC pair
  input  sample_t     [1:0] gen_dat_i,      // Generator pair
  output sample_t     [1:0] dac_src_dat_o,  // To DAC calibration
  input  sample_t     [1:0] dac_cal_dat_i,  // Back from DAC calibration
  output logic       [13:0] dac_dat_o,      // Combined DAC bus
  output logic              dac_sel_o,      // 0 ch0, 1 ch1
  output logic              dac_wrt_o
);

  sample_t [1:0] src_q;
  logic   [13:0] dat_q;
  logic          sel_q;
  logic          wrt_q;

  function automatic sample_t pick(src_e src, sample_t gen, sample_t adc);
    case (src)
      SRC_GEN:  return gen;
      SRC_LOOP: return adc;
      default:  return '0;  // SRC_OFF and unused code
    endcase
  endfunction

  //////////////////////////////
  // Source select
  //////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      src_q <= '0;
    end else begin
      src_q[0] <= pick(mux_cfg_i.src0, gen_dat_i[0], adc_dat_i[0]);
      src_q[1] <= pick(mux_cfg_i.src1, gen_dat_i[1], adc_dat_i[1]);
    end
  end

  assign dac_src_dat_o = src_q;

  //////////////////////////////
  // Interleaver
  //////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      wrt_q <= 1'b0;
      sel_q <= 1'b0;
      dat_q <= '0;
    end else begin
      wrt_q <= 1'b1;     // DAC takes a word every cycle
      sel_q <= ~sel_q;
      // Data follows the new select value
      dat_q <= sel_q ? dac_cal_dat_i[0] : dac_cal_dat_i[1];
    end
  end

  assign dac_dat_o = dat_q;
  assign dac_sel_o = sel_q;
  assign dac_wrt_o = wrt_q;

  // Channels must alternate while writing
  a_sel_toggle: assert property (
    @(posedge adc_clk) disable iff (top_rst) dac_wrt_o |=> (dac_sel_o != $past(dac_sel_o))
  ) else $error("DAC select did not toggle");

endmodule : dac_router

// ==== rtl/lin_calib.sv ====
/*
 * Linear gain and offset correction of one sample stream.
 * Stage one registers the signed product, stage two shifts,
 * adds the offset and saturates to 14 bits.
 */

module lin_calib import pitaya_pkg::*; (
  input  logic       adc_clk,
  input  logic       top_rst,
  input  sample_t    dat_i,   // Raw sample
  input  calib_cfg_t cfg_i,   // Gain and offset
  output sample_t    dat_o    // Corrected sample
);

  logic signed [29:0] prod_q;  // 14 x 16 bit product
  logic signed [29:0] shr_w;
  logic signed [17:0] acc_w;   // Headroom for offset add
  sample_t            sat_w;
  sample_t            dat_q;

  //////////////////////////////
  // Stage 1, multiply
  //////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) prod_q <= '0;
    else         prod_q <= dat_i * cfg_i.mul;  // Signed multiply
  end

  //////////////////////////////
  // Stage 2, shift, offset, clip
  //////////////////////////////

  assign shr_w = prod_q >>> CAL_SHIFT;  // Unity gain back to 1.0
  // Shifted product fits in 17 bits
  assign acc_w = $signed(shr_w[17:0]) + 18'(cfg_i.sum);

  always_comb begin
    if (acc_w > SMP_MAX) begin
      sat_w = SMP_MAX;          // Clip high
    end else if (acc_w < SMP_MIN) begin
      sat_w = SMP_MIN;          // Clip low
    end else begin
      sat_w = acc_w[13:0];
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) dat_q <= '0;
    else         dat_q <= sat_w;
  end

  assign dat_o = dat_q;

  // Known input and config must give a known result
  a_dat_known: assert property (
    @(posedge adc_clk) disable iff (top_rst) !$isunknown(dat_o)
  ) else $error("Calibrated sample is unknown");

endmodule : lin_calib

// ==== rtl/pitaya_core_top.sv ====
/*
 * Acquisition and generation core, two channels each way.
 * Register bank, ADC and DAC calibration, generators and router.
 */

module pitaya_core_top import pitaya_pkg::*; #(
  parameter logic [31:0] ID_VALUE = CORE_ID
) (
  input  logic             adc_clk,
  input  logic             top_rst,
  input  sample_t    [1:0] adc_dat_i,    // Raw ADC pair
  input  bus_req_t         bus_i,
  output logic      [31:0] bus_rdata_o,
  output logic             bus_rvalid_o,
  output logic      [13:0] dac_dat_o,
  output logic             dac_sel_o,
  output logic             dac_wrt_o
);

  calib_cfg_t [1:0] adc_cal;
  calib_cfg_t [1:0] dac_cal;
  gen_cfg_t   [1:0] gen_cfg;
  mux_cfg_t         mux_cfg;
  sample_t    [1:0] adc_cal_dat;  // Corrected ADC pair
  sample_t    [1:0] gen_dat;
  sample_t    [1:0] dac_src_dat;  // Selected DAC source
  sample_t    [1:0] dac_cal_dat;  // Corrected DAC pair

  //////////////////////////////
  // Control
  //////////////////////////////

  sys_regs #(.ID_VALUE (ID_VALUE)) i_regs (
    .adc_clk       (adc_clk     ),
    .top_rst       (top_rst     ),
    .bus_i         (bus_i       ),
    .bus_rdata_o   (bus_rdata_o ),
    .bus_rvalid_o  (bus_rvalid_o),
    .adc_cal_dat_i (adc_cal_dat ),
    .adc_cal_o     (adc_cal     ),
    .dac_cal_o     (dac_cal     ),
    .gen_cfg_o     (gen_cfg     ),
    .mux_cfg_o     (mux_cfg     )
  );

  //////////////////////////////
  // ADC calibration
  //////////////////////////////

  lin_calib i_adc_cal0 (.adc_clk (adc_clk), .top_rst (top_rst), .dat_i (adc_dat_i[0]),
                        .cfg_i (adc_cal[0]), .dat_o (adc_cal_dat[0]));
  lin_calib i_adc_cal1 (.adc_clk (adc_clk), .top_rst (top_rst), .dat_i (adc_dat_i[1]),
                        .cfg_i (adc_cal[1]), .dat_o (adc_cal_dat[1]));

  // Generators
  wave_gen i_gen0 (.adc_clk (adc_clk), .top_rst (top_rst), .cfg_i (gen_cfg[0]),
                   .dat_o (gen_dat[0]));
  wave_gen i_gen1 (.adc_clk (adc_clk), .top_rst (top_rst), .cfg_i (gen_cfg[1]),
                   .dat_o (gen_dat[1]));

  //////////////////////////////
  // DAC path
  //////////////////////////////

  lin_calib i_dac_cal0 (.adc_clk (adc_clk), .top_rst (top_rst), .dat_i (dac_src_dat[0]),
                        .cfg_i (dac_cal[0]), .dat_o (dac_cal_dat[0]));
  lin_calib i_dac_cal1 (.adc_clk (adc_clk), .top_rst (top_rst), .dat_i (dac_src_dat[1]),
                        .cfg_i (dac_cal[1]), .dat_o (dac_cal_dat[1]));

  dac_router i_router (
    .adc_clk       (adc_clk    ),
    .top_rst       (top_rst    ),
    .mux_cfg_i     (mux_cfg    ),
    .adc_dat_i     (adc_cal_dat),  // Loopback source
    .gen_dat_i     (gen_dat    ),
    .dac_src_dat_o (dac_src_dat),
    .dac_cal_dat_i (dac_cal_dat),
    .dac_dat_o     (dac_dat_o  ),
    .dac_sel_o     (dac_sel_o  ),
    .dac_wrt_o     (dac_wrt_o  )
  );

endmodule : pitaya_core_top

// ==== rtl/pitaya_pkg.sv ====
/*
 * Shared definitions for the scope and generator core.
 * Sample and calibration types, generator and routing configuration,
 * the register bus request and the register map.
 */

package pitaya_pkg;

  //////////////////////////////
  // Samples and calibration
  //////////////////////////////

  typedef logic signed [13:0] sample_t;   // ADC or DAC word
  typedef logic signed [15:0] cal_mul_t;  // Gain, 2.13 fixed point
  typedef logic signed [13:0] cal_sum_t;  // Offset in LSBs

  localparam cal_mul_t    CAL_UNITY = 16'sd8192;
  localparam int unsigned CAL_SHIFT = 13;

  // Saturation limits of a 14-bit sample
  localparam sample_t SMP_MAX = 14'sh1fff;  // 8191
  localparam sample_t SMP_MIN = 14'sh2000;  // -8192

  typedef struct packed {
    cal_mul_t mul;  // Bits 29:14
    cal_sum_t sum;  // Bits 13:0
  } calib_cfg_t;

  localparam calib_cfg_t CALIB_RST = '{mul: CAL_UNITY, sum: '0};

  //////////////////////////////
  // Generator and routing
  //////////////////////////////

  typedef enum logic [1:0] {
    WAVE_SAW    = 2'd0,
    WAVE_SQUARE = 2'd1,
    WAVE_DC     = 2'd2
  } wave_e;

  typedef struct packed {
    logic        en;
    wave_e       wave;
    logic [15:0] step;  // Phase increment, or DC value in low 14 bits
  } gen_cfg_t;

  localparam gen_cfg_t GEN_RST = '{en: 1'b0, wave: WAVE_SAW, step: '0};

  typedef enum logic [1:0] {
    SRC_OFF  = 2'd0,
    SRC_GEN  = 2'd1,
    SRC_LOOP = 2'd2
  } src_e;

  typedef struct packed {
    src_e src1;  // Bits 3:2
    src_e src0;  // Bits 1:0
  } mux_cfg_t;

  localparam mux_cfg_t MUX_RST = '{src1: SRC_OFF, src0: SRC_OFF};

  //////////////////////////////
  // Register bus
  //////////////////////////////

  typedef enum logic [3:0] {
    REG_MUX      = 4'd0,
    REG_ADC_CAL0 = 4'd1,
    REG_ADC_CAL1 = 4'd2,
    REG_DAC_CAL0 = 4'd3,
    REG_DAC_CAL1 = 4'd4,
    REG_GEN0     = 4'd5,
    REG_GEN1     = 4'd6,
    REG_CAPTURE  = 4'd7,
    REG_ID       = 4'd8
  } reg_addr_e;

  typedef struct packed {
    logic        wr;
    logic        rd;
    reg_addr_e   addr;
    logic [31:0] wdata;
  } bus_req_t;

  localparam logic [31:0] CORE_ID = 32'h5054_0201;  // Core tag and revision

endpackage : pitaya_pkg

// ==== rtl/sys_regs.sv ====
/*
 * Register bank of the core.
 * Decodes write and read strobes, holds every datapath setting
 * and keeps the latest corrected ADC pair for readback.
 */

module sys_regs import pitaya_pkg::*; #(
  parameter logic [31:0] ID_VALUE = CORE_ID
) (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // Bus
  input  bus_req_t             bus_i,
  output logic      [31:0]     bus_rdata_o,
  output logic                 bus_rvalid_o,
  // Capture source
  input  sample_t    [1:0]     adc_cal_dat_i,  // Corrected ADC pair
  // Configuration
  output calib_cfg_t [1:0]     adc_cal_o,
  output calib_cfg_t [1:0]     dac_cal_o,
  output gen_cfg_t   [1:0]     gen_cfg_o,
  output mux_cfg_t             mux_cfg_o
);

  calib_cfg_t [1:0] adc_cal_q;
  calib_cfg_t [1:0] dac_cal_q;
  gen_cfg_t   [1:0] gen_cfg_q;
  mux_cfg_t         mux_cfg_q;
  logic      [31:0] capture_q;  // Sign-extended halves
  logic      [31:0] rdata_w;
  logic      [31:0] rdata_q;
  logic             rvalid_q;

  // Register layouts
  function automatic calib_cfg_t cal_unpack(logic [31:0] w);
    return '{mul: cal_mul_t'(w[31:16]), sum: cal_sum_t'(w[13:0])};
  endfunction

  function automatic logic [31:0] cal_pack(calib_cfg_t c);
    return {c.mul, 2'b00, c.sum};
  endfunction

  function automatic gen_cfg_t gen_unpack(logic [31:0] w);
    return '{en: w[31], wave: wave_e'(w[25:24]), step: w[15:0]};
  endfunction

  function automatic logic [31:0] gen_pack(gen_cfg_t g);
    return {g.en, 5'b0, g.wave, 8'b0, g.step};
  endfunction

  //////////////////////////////
  // Write decode
  //////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_cal_q <= {2{CALIB_RST}};
      dac_cal_q <= {2{CALIB_RST}};
      gen_cfg_q <= {2{GEN_RST}};   // Generators off
      mux_cfg_q <= MUX_RST;        // DAC silent
    end else if (bus_i.wr) begin
      case (bus_i.addr)
        REG_MUX:      mux_cfg_q    <= mux_cfg_t'(bus_i.wdata[3:0]);
        REG_ADC_CAL0: adc_cal_q[0] <= cal_unpack(bus_i.wdata);
        REG_ADC_CAL1: adc_cal_q[1] <= cal_unpack(bus_i.wdata);
        REG_DAC_CAL0: dac_cal_q[0] <= cal_unpack(bus_i.wdata);
        REG_DAC_CAL1: dac_cal_q[1] <= cal_unpack(bus_i.wdata);
        REG_GEN0:     gen_cfg_q[0] <= gen_unpack(bus_i.wdata);
        REG_GEN1:     gen_cfg_q[1] <= gen_unpack(bus_i.wdata);
        default: ;                 // Read-only or unmapped
      endcase
    end
  end

  // Capture runs every cycle, no enable
  always_ff @(posedge adc_clk) begin
    capture_q <= {{2{adc_cal_dat_i[1][13]}}, adc_cal_dat_i[1],
                  {2{adc_cal_dat_i[0][13]}}, adc_cal_dat_i[0]};
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  always_comb begin
    case (bus_i.addr)
      REG_MUX:      rdata_w = {28'b0, mux_cfg_q};
      REG_ADC_CAL0: rdata_w = cal_pack(adc_cal_q[0]);
      REG_ADC_CAL1: rdata_w = cal_pack(adc_cal_q[1]);
      REG_DAC_CAL0: rdata_w = cal_pack(dac_cal_q[0]);
      REG_DAC_CAL1: rdata_w = cal_pack(dac_cal_q[1]);
      REG_GEN0:     rdata_w = gen_pack(gen_cfg_q[0]);
      REG_GEN1:     rdata_w = gen_pack(gen_cfg_q[1]);
      REG_CAPTURE:  rdata_w = capture_q;
      REG_ID:       rdata_w = ID_VALUE;
      default:      rdata_w = '0;  // Unknown address
    endcase
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) rvalid_q <= 1'b0;
    else         rvalid_q <= bus_i.rd;  // One-cycle pulse per strobe
  end

  always_ff @(posedge adc_clk) begin
    if (bus_i.rd) rdata_q <= rdata_w;
  end

  assign bus_rdata_o  = rdata_q;
  assign bus_rvalid_o = rvalid_q;
  assign adc_cal_o    = adc_cal_q;
  assign dac_cal_o    = dac_cal_q;
  assign gen_cfg_o    = gen_cfg_q;
  assign mux_cfg_o    = mux_cfg_q;

  // Bus master never issues both strobes together
  a_wr_rd_excl: assert property (
    @(posedge adc_clk) disable iff (top_rst) !(bus_i.wr && bus_i.rd)
  ) else $error("Write and read strobes overlap");

endmodule : sys_regs

// ==== rtl/wave_gen.sv ====
/*
 * Waveform generator for one DAC channel.
 * A 16-bit phase accumulator drives a sawtooth or square output,
 * or the step value is held as a constant level.
 */

module wave_gen import pitaya_pkg::*; (
  input  logic     adc_clk,
  input  logic     top_rst,
  input  gen_cfg_t cfg_i,   // Enable, shape, step
  output sample_t  dat_o
);

  logic [15:0] phase_q;
  sample_t     wave_w;
  sample_t     dat_q;

  //////////////////////////////
  // Phase accumulator
  //////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      phase_q <= '0;
    end else if (cfg_i.en) begin
      phase_q <= phase_q + cfg_i.step;  // Wraps modulo 2^16
    end else begin
      phase_q <= '0;                    // Restart from zero
    end
  end

  //////////////////////////////
  // Shape select
  //////////////////////////////

  always_comb begin
    case (cfg_i.wave)
      WAVE_SAW:    wave_w = sample_t'(phase_q[15:2]);  // Top 14 phase bits
      WAVE_SQUARE: wave_w = phase_q[15] ? SMP_MIN : SMP_MAX;
      WAVE_DC:     wave_w = sample_t'(cfg_i.step[13:0]);
      default:     wave_w = '0;
    endcase
  end

  // Output one cycle behind phase
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dat_q <= '0;
    end else if (cfg_i.en) begin
      dat_q <= wave_w;
    end else begin
      dat_q <= '0;  // Disabled, mid-scale
    end
  end

  assign dat_o = dat_q;

endmodule : wave_gen
